/* crc_ahb.f */
rtl/ahb_pkg.sv
rtl/crc_pkg.sv
rtl/host_interface.sv
rtl/data_buffer.sv
rtl/crc_engine.sv
rtl/crc_ahb.sv
dv/tb_clock_gen.sv
dv/crc_ahb_tb.sv

/* dv/crc_ahb_tb.sv */
// Self-checking testbench for the AHB-Lite CRC slave
// Single master and single slave, HREADY is held high by the master
// Expected CRCs come from a left-aligned reference model of the register map
`timescale 1ns/1ns

module crc_ahb_tb;

	import ahb_pkg::*;
	import crc_pkg::*;

	localparam int          CLK_PERIOD  = 10;
	localparam logic [31:0] INIT_RESET  = 32'hFFFF_FFFF;
	localparam logic [31:0] POLY_RESET  = 32'h04C1_1DB7;
	localparam int          N_RAND      = 24;
	// Upper bound on transfers over all tests
	localparam int          TOTAL_XFERS = 16 + 12 * (N_RAND + 5) + 4 * N_RAND;
	// Worst DR write waits for a whole word plus the handshake return
	localparam int          XFER_CYCLES = 16;
	localparam int          WATCHDOG_NS = (TOTAL_XFERS * XFER_CYCLES + 20) * CLK_PERIOD;

	logic        HCLK;
	logic        HRESETn;
	logic        HSEL;
	logic [31:0] HADDR;
	htrans_t     HTRANS;
	hsize_t      HSIZE;
	logic        HWRITE;
	logic [31:0] HWDATA;
	logic        HREADY;
	logic [31:0] HRDATA;
	logic        HREADYOUT;
	logic        HRESP;

	logic [31:0] lfsr_state;
	int          errors;
	int          checks;
	bit          bus_busy;

	// Reference model state
	logic [31:0] model_crc;
	logic [31:0] model_init;
	logic [31:0] model_poly;
	logic [1:0]  model_size;
	logic [1:0]  model_rev_in;
	logic        model_rev_out;

	tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(3)) i_clock_gen
	(
		.HCLK    (HCLK),
		.HRESETn (HRESETn)
	);

	crc_ahb #(.CRC_INIT_RESET(INIT_RESET)) i_crc_ahb
	(
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.HSEL      (HSEL),
		.HADDR     (HADDR),
		.HTRANS    (HTRANS),
		.HSIZE     (HSIZE),
		.HWRITE    (HWRITE),
		.HWDATA    (HWDATA),
		.HREADY    (HREADY),
		.HRDATA    (HRDATA),
		.HREADYOUT (HREADYOUT),
		.HRESP     (HRESP)
	);

	////////////////////////////////////////////////////////////
	// Stimulus source and reference model
	////////////////////////////////////////////////////////////

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] r;
		logic        fb;
		int          i;
		r = '0;
		for (i = 0; i < n; i++)
		begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic hsize_t rand_size();
		logic [31:0] r;
		r = rand_bits(2);
		case (r[1:0])
			2'd0:    return HSIZE_BYTE;
			2'd1:    return HSIZE_HALF;
			default: return HSIZE_WORD;
		endcase
	endfunction

	// Poly size code to width in bits
	function automatic int crc_width(logic [1:0] ps);
		case (ps)
			2'd0:    return 32;
			2'd1:    return 16;
			2'd2:    return 8;
			default: return 7;
		endcase
	endfunction

	// Mirror bits inside each span-wide chunk of the active bits
	function automatic logic [31:0] reflect(logic [31:0] d, int active, int span);
		logic [31:0] r;
		int          k;
		int          j;
		r = '0;
		for (k = 0; k < active; k += span)
		begin
			for (j = 0; j < span; j++)
				r[k + j] = d[k + span - 1 - j];
		end
		return r;
	endfunction

	// MSB-first over one byte, CRC and poly shifted to the top of the word
	function automatic logic [31:0] model_step(logic [31:0] c, logic [7:0] b);
		logic [31:0] r;
		logic [31:0] p;
		int          sh;
		int          i;
		sh = 32 - crc_width(model_size);
		r  = c << sh;
		p  = model_poly << sh;
		for (i = 7; i >= 0; i--)
		begin
			if (r[31] ^ b[i])
				r = (r << 1) ^ p;
			else
				r = r << 1;
		end
		return r >> sh;
	endfunction

	// One bus write, low lanes only, LSB byte first
	function automatic void model_feed(logic [31:0] d, hsize_t s);
		logic [31:0] v;
		int          nbytes;
		int          span;
		int          k;
		nbytes = (s == HSIZE_BYTE) ? 1 : (s == HSIZE_HALF) ? 2 : 4;
		span   = (model_rev_in == 2'd1) ? 8 : (model_rev_in == 2'd2) ? 16 : 32;
		// Reversal never spans more than the written lanes
		if (span > nbytes * 8)
			span = nbytes * 8;
		v = (model_rev_in == 2'd0) ? d : reflect(d, nbytes * 8, span);
		for (k = 0; k < nbytes; k++)
			model_crc = model_step(model_crc, v[k * 8 +: 8]);
	endfunction

	// Value the DR read should return
	function automatic logic [31:0] model_expected();
		logic [31:0] m;
		logic [31:0] c;
		int          w;
		w = crc_width(model_size);
		m = (w == 32) ? 32'hFFFF_FFFF : ((32'd1 << w) - 32'd1);
		c = model_crc & m;
		if (model_rev_out)
			c = reflect(c, w, w);
		return c;
	endfunction

	////////////////////////////////////////////////////////////
	// AHB master
	////////////////////////////////////////////////////////////

	// End of the current phase, HREADYOUT and HRDATA sampled at the falling edge
	task automatic wait_ready(output int stalls, output logic [31:0] rdata);
		stalls = 0;
		@(negedge HCLK);
		while (!HREADYOUT)
		begin
			stalls++;
			@(negedge HCLK);
		end
		rdata = HRDATA;
		@(posedge HCLK);
		#1;
	endtask

	task automatic drive_addr(logic [2:0] idx, logic wr, hsize_t s);
		HSEL   = 1'b1;
		HADDR  = {27'h0, idx, 2'b00};
		HTRANS = NONSEQ;
		HSIZE  = s;
		HWRITE = wr;
	endtask

	task automatic drive_idle();
		HSEL   = 1'b0;
		HTRANS = IDLE;
		HWRITE = 1'b0;
	endtask

	// Single transfer, address phase then data phase
	task automatic bus_access(logic [2:0] idx, logic wr, logic [31:0] wdata,
	                          output logic [31:0] rdata);
		int stalls;
		bus_busy = 1'b1;
		drive_addr(idx, wr, HSIZE_WORD);
		wait_ready(stalls, rdata);
		drive_idle();
		if (wr)
			HWDATA = wdata;
		wait_ready(stalls, rdata);
		bus_busy = 1'b0;
	endtask

	task automatic write_reg(logic [2:0] idx, logic [31:0] value);
		logic [31:0] unused;
		bus_access(idx, 1'b1, value, unused);
	endtask

	task automatic check_reg(logic [2:0] idx, logic [31:0] expected, string what);
		logic [31:0] rdata;
		bus_access(idx, 1'b0, 32'h0, rdata);
		checks++;
		assert (rdata == expected)
		else
		begin
			errors++;
			$display("error @ %0t: %s read %h, expected %h", $time, what, rdata, expected);
		end
	endtask

	task automatic check_dr(string what);
		check_reg(DR, model_expected(), what);
	endtask

	// Pipelined DR writes, next address phase overlaps the current data phase
	task automatic dr_stream(int count, bit mixed, output int stall_total);
		logic [31:0] cur_data;
		hsize_t      cur_size;
		logic [31:0] next_data;
		hsize_t      next_size;
		logic [31:0] unused;
		int          stalls;
		int          i;
		stall_total = 0;
		bus_busy    = 1'b1;
		cur_data    = rand_bits(32);
		cur_size    = mixed ? rand_size() : HSIZE_WORD;
		next_data   = cur_data;
		next_size   = cur_size;
		drive_addr(DR, 1'b1, cur_size);
		wait_ready(stalls, unused);
		for (i = 0; i < count; i++)
		begin
			// Each accepted write counts once, however long it stalls
			HWDATA = cur_data;
			model_feed(cur_data, cur_size);
			if (i < count - 1)
			begin
				next_data = rand_bits(32);
				next_size = mixed ? rand_size() : HSIZE_WORD;
				drive_addr(DR, 1'b1, next_size);
			end
			else
				drive_idle();
			wait_ready(stalls, unused);
			stall_total += stalls;
			cur_data = next_data;
			cur_size = next_size;
		end
		bus_busy = 1'b0;
	endtask

	// POL, INIT, then CR with the reload strobe, model follows
	task automatic configure(logic [1:0] ps, logic [1:0] rin, logic rout,
	                         logic [31:0] init, logic [31:0] poly);
		write_reg(POL, poly);
		write_reg(INIT, init);
		write_reg(CR, {24'h0, rout, rin, ps, 3'b001});
		model_poly    = poly;
		model_init    = init;
		model_size    = ps;
		model_rev_in  = rin;
		model_rev_out = rout;
		model_crc     = init;
		// Strobe bit reads back as zero
		check_reg(CR, {24'h0, rout, rin, ps, 3'b000}, "CR");
	endtask

	////////////////////////////////////////////////////////////
	// Cycle checks
	////////////////////////////////////////////////////////////

	always @(negedge HCLK)
	begin
		if (HRESETn)
		begin
			assert (HRESP == 1'b0)
			else
			begin
				errors++;
				$display("error @ %0t: HRESP is not OKAY", $time);
			end
			// No transfer in flight, so no wait state
			if (!bus_busy)
			begin
				assert (HREADYOUT)
				else
				begin
					errors++;
					$display("error @ %0t: HREADYOUT low while the bus is idle", $time);
				end
			end
		end
	end

	// Watchdog
	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the DUT stopped completing transfers",
		         WATCHDOG_NS);
		$display("Simulation failed");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		logic [31:0] v;
		int          stalls;
		int          ps;
		int          rin;
		int          rout;
		lfsr_state    = 32'h6ecd;
		errors        = 0;
		checks        = 0;
		bus_busy      = 1'b0;
		HSEL          = 1'b0;
		HADDR         = 32'h0;
		HTRANS        = IDLE;
		HSIZE         = HSIZE_WORD;
		HWRITE        = 1'b0;
		HWDATA        = 32'h0;
		HREADY        = 1'b1;
		model_crc     = INIT_RESET;
		model_init    = INIT_RESET;
		model_poly    = POLY_RESET;
		model_size    = 2'd0;
		model_rev_in  = 2'd0;
		model_rev_out = 1'b0;
		@(posedge HRESETn);
		@(posedge HCLK);
		#1;

		// Reset values and IDR
		check_reg(CR, 32'h0, "CR after reset");
		check_reg(INIT, INIT_RESET, "INIT after reset");
		check_reg(POL, POLY_RESET, "POL after reset");
		check_dr("DR after reset");
		v = rand_bits(32);
		write_reg(IDR, v);
		check_reg(IDR, {24'h0, v[7:0]}, "IDR");

		// 32-bit poly, words only
		dr_stream(N_RAND, 1'b0, stalls);
		check_dr("P32 words");

		// Narrow polynomials with mixed sizes
		for (ps = 1; ps < 4; ps++)
		begin
			configure(ps[1:0], 2'd0, 1'b0, rand_bits(32), rand_bits(32) | 32'h1);
			dr_stream(N_RAND, 1'b1, stalls);
			check_dr("narrow poly");
		end

		// Every input reversal with output reversal off and on
		for (rin = 0; rin < 4; rin++)
		begin
			for (rout = 0; rout < 2; rout++)
			begin
				configure(2'd0, rin[1:0], rout[0], rand_bits(32), POLY_RESET);
				dr_stream(N_RAND, 1'b1, stalls);
				check_dr("reversal");
			end
		end

		// Back-to-back writes under engine back-pressure
		configure(2'd0, 2'd0, 1'b0, INIT_RESET, POLY_RESET);
		dr_stream(2 * N_RAND, 1'b1, stalls);
		checks++;
		assert (stalls > 0)
		else
		begin
			errors++;
			$display("error @ %0t: back-to-back DR writes never stalled", $time);
		end
		check_dr("back-to-back");

		// New INIT, then chain reset drops the earlier data
		dr_stream(N_RAND / 2, 1'b1, stalls);
		v = rand_bits(32);
		write_reg(INIT, v);
		model_init = v;
		check_dr("before chain reset");
		check_reg(INIT, v, "new INIT");
		write_reg(CR, {24'h0, model_rev_out, model_rev_in, model_size, 3'b001});
		model_crc = model_init;
		dr_stream(N_RAND, 1'b1, stalls);
		check_dr("after chain reset");

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* dv/tb_clock_gen.sv */
// Clock and reset source for the testbench
// Reset is released a fixed delay after a rising edge
`timescale 1ns/1ns

module tb_clock_gen
#(
	parameter int PERIOD_NS    = 10,
	parameter int RESET_CYCLES = 3
)
(
	output logic HCLK,
	output logic HRESETn
);

	// Free running clock
	initial
	begin
		HCLK = 1'b0;
		forever
			#(PERIOD_NS / 2) HCLK = ~HCLK;
	end

	// Active low reset held for a whole number of cycles
	initial
	begin
		HRESETn = 1'b0;
		repeat (RESET_CYCLES)
			@(posedge HCLK);
		#1;
		HRESETn = 1'b1;
	end

endmodule

/* rtl/crc_ahb.sv */
// CRC accelerator with an AHB-Lite slave port
// CRC_INIT_RESET sets the reset value of INIT and of the running CRC
`timescale 1ns/1ns

module crc_ahb
#(
	parameter logic [31:0] CRC_INIT_RESET = 32'hFFFF_FFFF
)
(
	input  logic             HCLK,
	input  logic             HRESETn,
	input  logic             HSEL,
	input  logic [31:0]      HADDR,
	input  ahb_pkg::htrans_t HTRANS,
	input  ahb_pkg::hsize_t  HSIZE,
	input  logic             HWRITE,
	input  logic [31:0]      HWDATA,
	input  logic             HREADY,
	output logic [31:0]      HRDATA,
	output logic             HREADYOUT,
	output logic             HRESP
);

	import crc_pkg::*;

	// Host to buffer
	logic        buffer_write_en;
	crc_word_t   buffer_word;
	logic        buffer_full;
	// Buffer to engine handshake
	logic        word_req;
	logic        word_ack;
	crc_word_t   word;
	// Host to engine
	crc_cfg_t    cfg;
	logic        reset_chain;
	logic        crc_init_en;
	logic        crc_poly_en;
	logic        crc_idr_en;
	logic [31:0] bus_wr;
	// Engine status and read values
	logic [31:0] crc_out;
	logic [31:0] crc_init_out;
	logic [31:0] crc_poly_out;
	logic [7:0]  crc_idr_out;
	logic        reset_pending;
	logic        read_wait;

	host_interface i_host_interface
	(
		.HCLK            (HCLK),
		.HRESETn         (HRESETn),
		.HSEL            (HSEL),
		.HADDR           (HADDR),
		.HTRANS          (HTRANS),
		.HSIZE           (HSIZE),
		.HWRITE          (HWRITE),
		.HWDATA          (HWDATA),
		.HREADY          (HREADY),
		.HRDATA          (HRDATA),
		.HREADYOUT       (HREADYOUT),
		.HRESP           (HRESP),
		.buffer_full     (buffer_full),
		.buffer_write_en (buffer_write_en),
		.buffer_word     (buffer_word),
		.crc_out         (crc_out),
		.crc_init_out    (crc_init_out),
		.crc_poly_out    (crc_poly_out),
		.crc_idr_out     (crc_idr_out),
		.reset_pending   (reset_pending),
		.read_wait       (read_wait),
		.cfg             (cfg),
		.reset_chain     (reset_chain),
		.crc_init_en     (crc_init_en),
		.crc_poly_en     (crc_poly_en),
		.crc_idr_en      (crc_idr_en),
		.bus_wr          (bus_wr)
	);

	data_buffer i_data_buffer
	(
		.HCLK            (HCLK),
		.HRESETn         (HRESETn),
		.buffer_write_en (buffer_write_en),
		.buffer_word     (buffer_word),
		.word_ack        (word_ack),
		.full            (buffer_full),
		.word_req        (word_req),
		.word            (word)
	);

	crc_engine #(.CRC_INIT_RESET(CRC_INIT_RESET)) i_crc_engine
	(
		.HCLK          (HCLK),
		.HRESETn       (HRESETn),
		.cfg           (cfg),
		.reset_chain   (reset_chain),
		.crc_init_en   (crc_init_en),
		.crc_poly_en   (crc_poly_en),
		.crc_idr_en    (crc_idr_en),
		.bus_wr        (bus_wr),
		.word_req      (word_req),
		.word          (word),
		.word_ack      (word_ack),
		.crc_out       (crc_out),
		.crc_init_out  (crc_init_out),
		.crc_poly_out  (crc_poly_out),
		.crc_idr_out   (crc_idr_out),
		.reset_pending (reset_pending),
		.read_wait     (read_wait)
	);

endmodule

/* rtl/crc_engine.sv */
// Byte-serial CRC, one byte per clock, LSB byte of the word first
// Input reversal span is clamped to the written size, a byte is never
// reversed across lanes it does not occupy
`timescale 1ns/1ns

module crc_engine
#(
	parameter logic [31:0] CRC_INIT_RESET = 32'hFFFF_FFFF
)
(
	input  logic               HCLK,
	input  logic               HRESETn,
	input  crc_pkg::crc_cfg_t  cfg,
	input  logic               reset_chain,
	input  logic               crc_init_en,
	input  logic               crc_poly_en,
	input  logic               crc_idr_en,
	input  logic [31:0]        bus_wr,
	input  logic               word_req,
	input  crc_pkg::crc_word_t word,
	output logic               word_ack,
	output logic [31:0]        crc_out,
	output logic [31:0]        crc_init_out,
	output logic [31:0]        crc_poly_out,
	output logic [7:0]         crc_idr_out,
	output logic               reset_pending,
	output logic               read_wait
);

	import ahb_pkg::*;
	import crc_pkg::*;

	logic [31:0] crc_q;
	logic [31:0] init_q;
	logic [31:0] poly_q;
	logic [7:0]  idr_q;
	logic [1:0]  cnt_q;
	logic        ack_q;
	logic        pending_q;
	logic        active;
	logic        idle;
	logic [1:0]  last_cnt;
	logic [31:0] data_rev;
	logic [7:0]  byte_in;

	////////////////////////////////////////////////////////////
	// Width and reversal helpers
	////////////////////////////////////////////////////////////

	function automatic int width_of(poly_size_t s);
		case (s)
			P32:     return 32;
			P16:     return 16;
			P8:      return 8;
			default: return 7;
		endcase
	endfunction

	// Never wider than the data actually written
	function automatic rev_in_t clamp_rev(rev_in_t m, hsize_t s);
		case (s)
			HSIZE_BYTE: return (m == REV_NONE) ? REV_NONE : REV_BYTE;
			HSIZE_HALF: return (m == REV_WORD) ? REV_HALF : m;
			default:    return m;
		endcase
	endfunction

	function automatic logic [31:0] reverse_in(logic [31:0] d, rev_in_t m);
		logic [31:0] r;
		int          i;
		for (i = 0; i < 32; i++)
		begin
			case (m)
				REV_BYTE: r[i] = d[(i / 8) * 8 + 7 - (i % 8)];
				REV_HALF: r[i] = d[(i / 16) * 16 + 15 - (i % 16)];
				REV_WORD: r[i] = d[31 - i];
				default:  r[i] = d[i];
			endcase
		end
		return r;
	endfunction

	// MSB-first update over one byte, CRC right-aligned in its width
	function automatic logic [31:0] crc_fold(logic [31:0] c_in, logic [7:0] b,
	                                         logic [31:0] poly, poly_size_t s);
		logic [31:0] mask;
		logic [31:0] c;
		logic        fb;
		int          top;
		int          i;
		mask = 32'hFFFF_FFFF >> (32 - width_of(s));
		top  = width_of(s) - 1;
		c    = c_in & mask;
		for (i = 7; i >= 0; i--)
		begin
			fb = c[top] ^ b[i];
			c  = (c << 1) & mask;
			if (fb)
				c = c ^ (poly & mask);
		end
		return c;
	endfunction

	// Masked result, optionally bit reversed within the width
	function automatic logic [31:0] crc_result(logic [31:0] c, poly_size_t s, logic rev);
		logic [31:0] r;
		int          w;
		int          i;
		w = width_of(s);
		r = '0;
		for (i = 0; i < 32; i++)
		begin
			if (i < w)
				r[i] = rev ? c[w - 1 - i] : c[i];
		end
		return r;
	endfunction

	////////////////////////////////////////////////////////////
	// Byte stepping
	////////////////////////////////////////////////////////////

	// Busy from req until ack has dropped again
	assign active = word_req && !ack_q;
	assign idle   = !word_req && !ack_q && (cnt_q == 2'd0);

	always_comb
	begin
		case (word.size)
			HSIZE_BYTE: last_cnt = 2'd0;
			HSIZE_HALF: last_cnt = 2'd1;
			default:    last_cnt = 2'd3;
		endcase
	end

	assign data_rev = reverse_in(word.data, clamp_rev(cfg.rev_in, word.size));
	assign byte_in  = data_rev[{cnt_q, 3'b000} +: 8];

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			crc_q     <= CRC_INIT_RESET;
			init_q    <= CRC_INIT_RESET;
			poly_q    <= CRC_POLY_RESET;
			idr_q     <= 8'h00;
			cnt_q     <= 2'd0;
			ack_q     <= 1'b0;
			pending_q <= 1'b0;
		end
		else
		begin
			if (crc_init_en)
				init_q <= bus_wr;
			if (crc_poly_en)
				poly_q <= bus_wr;
			if (crc_idr_en)
				idr_q <= bus_wr[7:0];

			if (active)
			begin
				crc_q <= crc_fold(crc_q, byte_in, poly_q, cfg.poly_size);
				// Ack one cycle after the last byte
				if (cnt_q == last_cnt)
				begin
					cnt_q <= 2'd0;
					ack_q <= 1'b1;
				end
				else
					cnt_q <= cnt_q + 2'd1;
			end
			else if (ack_q && !word_req)
				ack_q <= 1'b0;

			// Chain reset waits for the engine to go idle
			if ((reset_chain || pending_q) && idle)
				crc_q <= init_q;
			pending_q <= (reset_chain || pending_q) && !idle;
		end
	end

	assign word_ack      = ack_q;
	assign read_wait     = word_req || ack_q;
	assign reset_pending = pending_q;
	assign crc_out       = crc_result(crc_q, cfg.poly_size, cfg.rev_out);
	assign crc_init_out  = init_q;
	assign crc_poly_out  = poly_q;
	assign crc_idr_out   = idr_q;

endmodule

/* rtl/data_buffer.sv */
// One word of input buffering between the bus and the CRC engine
// Full stays high until the req/ack handshake has fully returned to idle
`timescale 1ns/1ns

module data_buffer
(
	input  logic               HCLK,
	input  logic               HRESETn,
	input  logic               buffer_write_en,
	input  crc_pkg::crc_word_t buffer_word,
	input  logic               word_ack,
	output logic               full,
	output logic               word_req,
	output crc_pkg::crc_word_t word
);

	import crc_pkg::*;

	crc_word_t word_q;
	logic      full_q;
	logic      req_q;

	// Holding register, loaded only when empty
	always_ff @(posedge HCLK)
	begin
		if (buffer_write_en && !full_q)
			word_q <= buffer_word;
	end

	// Four-phase handshake
	// Empty implies ack already low, so req may rise at capture
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			full_q <= 1'b0;
			req_q  <= 1'b0;
		end
		else if (buffer_write_en && !full_q)
		begin
			full_q <= 1'b1;
			req_q  <= 1'b1;
		end
		else if (req_q && word_ack)
			req_q <= 1'b0;
		else if (full_q && !req_q && !word_ack)
			full_q <= 1'b0;
	end

	assign full     = full_q;
	assign word_req = req_q;
	assign word     = word_q;

endmodule

/* rtl/host_interface.sv */
// AHB-Lite slave front end of the CRC unit
// Only NONSEQ transfers are decoded, SEQ and BUSY are ignored
// HRESP is always OKAY, wait states come from the buffer and the engine
`timescale 1ns/1ns

module host_interface
(
	input  logic                 HCLK,
	input  logic                 HRESETn,
	// AHB-Lite slave
	input  logic                 HSEL,
	input  logic [31:0]          HADDR,
	input  ahb_pkg::htrans_t     HTRANS,
	input  ahb_pkg::hsize_t      HSIZE,
	input  logic                 HWRITE,
	input  logic [31:0]          HWDATA,
	input  logic                 HREADY,
	output logic [31:0]          HRDATA,
	output logic                 HREADYOUT,
	output logic                 HRESP,
	// Data buffer
	input  logic                 buffer_full,
	output logic                 buffer_write_en,
	output crc_pkg::crc_word_t   buffer_word,
	// CRC engine
	input  logic [31:0]          crc_out,
	input  logic [31:0]          crc_init_out,
	input  logic [31:0]          crc_poly_out,
	input  logic [7:0]           crc_idr_out,
	input  logic                 reset_pending,
	input  logic                 read_wait,
	output crc_pkg::crc_cfg_t    cfg,
	output logic                 reset_chain,
	output logic                 crc_init_en,
	output logic                 crc_poly_en,
	output logic                 crc_idr_en,
	output logic [31:0]          bus_wr
);

	import ahb_pkg::*;
	import crc_pkg::*;

	ahb_addr_phase_t ap;
	crc_cfg_t        cfg_q;
	logic            sample_bus;
	logic            write_en;
	logic            read_en;
	logic            dr_write;
	logic            dr_read;
	logic            init_write;
	logic            cr_write;

	////////////////////////////////////////////////////////////
	// Address phase pipeline
	////////////////////////////////////////////////////////////

	// New address phase only when the current data phase ends
	assign sample_bus = HREADY && HREADYOUT;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			ap.sel   <= 1'b0;
			ap.trans <= IDLE;
		end
		else if (sample_bus)
		begin
			ap <= '{addr: HADDR[4:2], size: HSIZE, trans: HTRANS, write: HWRITE, sel: HSEL};
		end
	end

	////////////////////////////////////////////////////////////
	// Data phase decode
	////////////////////////////////////////////////////////////

	assign write_en = ap.sel && (ap.trans == NONSEQ) && ap.write;
	assign read_en  = ap.sel && (ap.trans == NONSEQ) && !ap.write;

	assign dr_write   = write_en && (ap.addr == DR);
	assign dr_read    = read_en && (ap.addr == DR);
	assign init_write = write_en && (ap.addr == INIT);
	assign cr_write   = write_en && (ap.addr == CR);

	// Buffer takes the word once it has room
	assign buffer_write_en = dr_write;
	assign buffer_word     = '{data: HWDATA, size: ap.size};

	// INIT is held off until a pending chain reset has reloaded the CRC
	assign crc_init_en = init_write && !reset_pending;
	assign crc_poly_en = write_en && (ap.addr == POL);
	assign crc_idr_en  = write_en && (ap.addr == IDR);
	assign bus_wr      = HWDATA;

	// Bit 0 of CR is a strobe, never stored
	assign reset_chain = cr_write && HWDATA[0];

	// Wait states
	assign HREADYOUT = !((dr_write && buffer_full) ||
	                     (dr_read && read_wait) ||
	                     (init_write && reset_pending));

	assign HRESP = 1'b0;

	////////////////////////////////////////////////////////////
	// Control register and read mux
	////////////////////////////////////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			cfg_q <= '0;
		else if (cr_write)
			cfg_q <= crc_cfg_t'(HWDATA[7:3]);
	end

	assign cfg = cfg_q;

	always_comb
	begin
		case (ap.addr)
			DR:      HRDATA = crc_out;
			IDR:     HRDATA = {24'h0, crc_idr_out};
			CR:      HRDATA = {24'h0, cfg_q, 3'b000};
			INIT:    HRDATA = crc_init_out;
			POL:     HRDATA = crc_poly_out;
			default: HRDATA = 32'h0;
		endcase
	end

endmodule

/* rtl/crc_pkg.sv */
// Register map and configuration types of the CRC unit
// Polynomial reset value is fixed here, the initial value comes from the top

package crc_pkg;

	// Register word offsets
	typedef enum logic [2:0]
	{
		DR   = 3'd0,
		IDR  = 3'd1,
		CR   = 3'd2,
		INIT = 3'd4,
		POL  = 3'd5
	} crc_reg_t;

	// Polynomial width
	typedef enum logic [1:0]
	{
		P32 = 2'd0,
		P16 = 2'd1,
		P8  = 2'd2,
		P7  = 2'd3
	} poly_size_t;

	// Input bit reversal span
	typedef enum logic [1:0]
	{
		REV_NONE = 2'd0,
		REV_BYTE = 2'd1,
		REV_HALF = 2'd2,
		REV_WORD = 2'd3
	} rev_in_t;

	// Stored control register, read back at CR bits 7:3
	typedef struct packed
	{
		logic       rev_out;    // CR bit 7
		rev_in_t    rev_in;     // CR bits 6:5
		poly_size_t poly_size;  // CR bits 4:3
	} crc_cfg_t;

	// One bus write as handed to the engine
	typedef struct packed
	{
		logic [31:0]     data;
		ahb_pkg::hsize_t size;
	} crc_word_t;

	localparam logic [31:0] CRC_POLY_RESET = 32'h04C1_1DB7;

endpackage

/* rtl/ahb_pkg.sv */
// AHB-Lite encodings used by the CRC slave
// Only the sizes up to one word are listed, wider transfers are not supported

package ahb_pkg;

	// Transfer type on HTRANS
	typedef enum logic [1:0]
	{
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_t;

	// Transfer size on HSIZE
	typedef enum logic [2:0]
	{
		HSIZE_BYTE = 3'b000,
		HSIZE_HALF = 3'b001,
		HSIZE_WORD = 3'b010
	} hsize_t;

	// Address phase as held for the data phase
	typedef struct packed
	{
		logic [2:0] addr;   // Word offset, HADDR[4:2]
		hsize_t     size;
		htrans_t    trans;
		logic       write;
		logic       sel;
	} ahb_addr_phase_t;

endpackage
